// ==== lane_cfg_pkg.sv ====
package lane_cfg_pkg;

    //////////////////////////////////////////////////////////////////////
    // Lane sizes
    //////////////////////////////////////////////////////////////////////

    // One ALU slot per VRF write port
    localparam int NUM_WR_PORTS = 2;
    // Two operand read ports per slot
    localparam int NUM_RD_PORTS = 2 * NUM_WR_PORTS;
    localparam int VREG_DEPTH   = 32;

    //////////////////////////////////////////////////////////////////////
    // Pipeline timing, counted in edges from issue
    //////////////////////////////////////////////////////////////////////

    // Address register plus output register of the VRF
    localparam int READ_LAT    = 2;
    localparam int EXEC_LAT    = 3;
    localparam int WRITE_VIS   = 5;
    // Control is sampled at issue and must meet the prepared operands
    localparam int CTRL_STAGES = READ_LAT + 1;

    //////////////////////////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [$clog2(VREG_DEPTH)-1:0] vreg_addr_t;
    typedef logic [$clog2(NUM_RD_PORTS)-1:0] rd_sel_t;
    typedef logic [1:0] sew_t;
    typedef logic [1:0] elem_sel_t;

    // Element width codes
    localparam sew_t SEW_8   = 2'd0;
    localparam sew_t SEW_16  = 2'd1;
    localparam sew_t SEW_32  = 2'd2;

endpackage

// ==== lane_op_pkg.sv ====
package lane_op_pkg;

    //////////////////////////////////////////////////////////////////////
    // Operation codes
    //////////////////////////////////////////////////////////////////////

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t OP_ADD  = 3'd0;
    localparam alu_op_t OP_SUB  = 3'd1;
    localparam alu_op_t OP_AND  = 3'd2;
    localparam alu_op_t OP_OR   = 3'd3;
    localparam alu_op_t OP_XOR  = 3'd4;
    localparam alu_op_t OP_SLL  = 3'd5;
    localparam alu_op_t OP_SRL  = 3'd6;
    localparam alu_op_t OP_MAXU = 3'd7;

    // Second operand source, code 3 gives zero
    typedef logic [1:0] op2_sel_t;
    localparam op2_sel_t SRC_VEC = 2'd0;
    localparam op2_sel_t SRC_X   = 2'd1;
    localparam op2_sel_t SRC_IMM = 2'd2;

    // Writeback data source
    typedef logic wb_sel_t;
    localparam wb_sel_t WB_ALU  = 1'b0;
    localparam wb_sel_t WB_LOAD = 1'b1;

    //////////////////////////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        lane_cfg_pkg::vreg_addr_t raddr;
        lane_cfg_pkg::elem_sel_t  elem_sel;
    } rd_req_t;

    typedef struct packed {
        logic                     valid;
        alu_op_t                  alu_op;
        op2_sel_t                 op2_sel;
        lane_cfg_pkg::word_t      x_data;
        logic [4:0]               imm;
        wb_sel_t                  wb_sel;
        lane_cfg_pkg::vreg_addr_t waddr;
        lane_cfg_pkg::byte_en_t   byte_en;
        lane_cfg_pkg::word_t      load_data;
        logic                     store_valid;
        lane_cfg_pkg::rd_sel_t    store_sel;
    } slot_op_t;

    // Result and store outputs share this shape
    typedef struct packed {
        logic                valid;
        lane_cfg_pkg::word_t data;
    } lane_out_t;

    typedef struct packed {
        lane_cfg_pkg::vreg_addr_t waddr;
        lane_cfg_pkg::word_t      wdata;
        lane_cfg_pkg::byte_en_t   byte_en;
    } wr_req_t;

endpackage

// ==== lane_vrf.sv ====
module lane_vrf (
    input  logic                                              clk_i,
    input  lane_op_pkg::rd_req_t [lane_cfg_pkg::NUM_RD_PORTS-1:0] rd_req_i,
    input  lane_op_pkg::wr_req_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] wr_i,
    output lane_cfg_pkg::word_t  [lane_cfg_pkg::NUM_RD_PORTS-1:0] rdata_o
);

    import lane_cfg_pkg::*;

    // Register array, contents undefined after reset
    word_t mem [VREG_DEPTH];

    // Read addresses captured at issue
    vreg_addr_t [NUM_RD_PORTS-1:0] raddr_q;

    //////////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////////

    // First read cycle: address only
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            raddr_q[p] <= rd_req_i[p].raddr;
        end
    end

    // Second read cycle: array into output register
    // A write on this same edge is not seen yet
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            rdata_o[p] <= mem[raddr_q[p]];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////////

    // Ports applied in index order
    // Last assignment wins, so the higher port owns shared bytes
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < NUM_WR_PORTS; w++) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_i[w].byte_en[b]) begin
                    mem[wr_i[w].waddr][8*b +: 8] <= wr_i[w].wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== lane_read_prep.sv ====
module lane_read_prep (
    input  logic                                                clk_i,
    input  logic                                                rst_i,
    input  lane_cfg_pkg::sew_t                                  sew_i,
    input  lane_cfg_pkg::elem_sel_t [lane_cfg_pkg::NUM_RD_PORTS-1:0] elem_sel_i,
    input  lane_cfg_pkg::word_t     [lane_cfg_pkg::NUM_RD_PORTS-1:0] rdata_i,
    output lane_cfg_pkg::word_t     [lane_cfg_pkg::NUM_RD_PORTS-1:0] elem_o
);

    import lane_cfg_pkg::*;

    // Index sampled at issue, then held one more cycle
    // Last stage lines up with the VRF output register
    elem_sel_t [READ_LAT-1:0][NUM_RD_PORTS-1:0] sel_q;
    word_t     [NUM_RD_PORTS-1:0]               elem_d;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            sel_q <= '0;
        end else begin
            sel_q[0] <= elem_sel_i;
            for (int s = 1; s < READ_LAT; s++) begin
                sel_q[s] <= sel_q[s-1];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Element extraction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [7:0]  byte_v;
        logic [15:0] half_v;
        elem_sel_t   idx;
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            idx    = sel_q[READ_LAT-1][p];
            byte_v = rdata_i[p][8*idx +: 8];
            // Halfword index uses the low bit only
            half_v = rdata_i[p][16*idx[0] +: 16];
            // Zero extension only, no signed elements
            case (sew_i)
                SEW_8:   elem_d[p] = {24'b0, byte_v};
                SEW_16:  elem_d[p] = {16'b0, half_v};
                SEW_32:  elem_d[p] = rdata_i[p];
                default: elem_d[p] = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        elem_o <= elem_d;
    end

endmodule

// ==== lane_ctrl_pipe.sv ====
module lane_ctrl_pipe (
    input  logic                                                 clk_i,
    input  logic                                                 rst_i,
    input  lane_op_pkg::slot_op_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] slot_op_i,
    output lane_op_pkg::slot_op_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] slot_op_o
);

    import lane_cfg_pkg::*;
    import lane_op_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Control delay line
    //////////////////////////////////////////////////////////////////////

    // Stage 0 samples at issue
    // Two more stages cover the VRF read and element extraction
    // One operation may sit in every stage at once
    slot_op_t [CTRL_STAGES-1:0][NUM_WR_PORTS-1:0] stage_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            // Valid bits of all stages drop together
            stage_q <= '0;
        end else begin
            stage_q[0] <= slot_op_i;
            for (int s = 1; s < CTRL_STAGES; s++) begin
                stage_q[s] <= stage_q[s-1];
            end
        end
    end

    // Oldest stage meets the registered elements
    assign slot_op_o = stage_q[CTRL_STAGES-1];

endmodule

// ==== lane_exec.sv ====
module lane_exec (
    input  logic                                                  clk_i,
    input  logic                                                  rst_i,
    input  lane_cfg_pkg::word_t    [lane_cfg_pkg::NUM_RD_PORTS-1:0] elem_i,
    input  lane_op_pkg::slot_op_t  [lane_cfg_pkg::NUM_WR_PORTS-1:0] op_i,
    output lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] result_o,
    output lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] store_o
);

    import lane_cfg_pkg::*;
    import lane_op_pkg::*;

    word_t [NUM_WR_PORTS-1:0] op1;
    word_t [NUM_WR_PORTS-1:0] op2;
    word_t [NUM_WR_PORTS-1:0] alu_d;
    word_t [NUM_WR_PORTS-1:0] store_d;

    // Output registers, valid bits split from data
    logic  [NUM_WR_PORTS-1:0] res_valid_q;
    logic  [NUM_WR_PORTS-1:0] st_valid_q;
    word_t [NUM_WR_PORTS-1:0] res_data_q;
    word_t [NUM_WR_PORTS-1:0] st_data_q;

    //////////////////////////////////////////////////////////////////////
    // Operand select and ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < NUM_WR_PORTS; j++) begin
            // Slot j owns read ports 2j and 2j+1
            op1[j] = elem_i[2*j];
            case (op_i[j].op2_sel)
                SRC_VEC: op2[j] = elem_i[2*j+1];
                SRC_X:   op2[j] = op_i[j].x_data;
                SRC_IMM: op2[j] = {27'b0, op_i[j].imm};
                default: op2[j] = '0;
            endcase

            case (op_i[j].alu_op)
                OP_ADD:  alu_d[j] = op1[j] + op2[j];
                OP_SUB:  alu_d[j] = op1[j] - op2[j];
                OP_AND:  alu_d[j] = op1[j] & op2[j];
                OP_OR:   alu_d[j] = op1[j] | op2[j];
                OP_XOR:  alu_d[j] = op1[j] ^ op2[j];
                // Shift amount is the low 5 bits
                OP_SLL:  alu_d[j] = op1[j] << op2[j][4:0];
                OP_SRL:  alu_d[j] = op1[j] >> op2[j][4:0];
                default: alu_d[j] = (op1[j] > op2[j]) ? op1[j] : op2[j];
            endcase

            // Store data may come from any read port
            store_d[j] = elem_i[op_i[j].store_sel];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            res_valid_q <= '0;
            st_valid_q  <= '0;
        end else begin
            for (int j = 0; j < NUM_WR_PORTS; j++) begin
                res_valid_q[j] <= op_i[j].valid;
                st_valid_q[j]  <= op_i[j].store_valid;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        res_data_q <= alu_d;
        st_data_q  <= store_d;
    end

    always_comb begin
        for (int j = 0; j < NUM_WR_PORTS; j++) begin
            result_o[j].valid = res_valid_q[j];
            result_o[j].data  = res_data_q[j];
            store_o[j].valid  = st_valid_q[j];
            store_o[j].data   = st_data_q[j];
        end
    end

endmodule

// ==== lane_writeback.sv ====
module lane_writeback (
    input  logic                                                  clk_i,
    input  logic                                                  rst_i,
    input  lane_op_pkg::slot_op_t  [lane_cfg_pkg::NUM_WR_PORTS-1:0] op_i,
    input  lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] result_i,
    output lane_op_pkg::wr_req_t   [lane_cfg_pkg::NUM_WR_PORTS-1:0] wr_o
);

    import lane_cfg_pkg::*;
    import lane_op_pkg::*;

    // Copy of the write fields, one stage behind the ALU inputs
    logic       [NUM_WR_PORTS-1:0] valid_q;
    vreg_addr_t [NUM_WR_PORTS-1:0] waddr_q;
    wb_sel_t    [NUM_WR_PORTS-1:0] wb_sel_q;
    byte_en_t   [NUM_WR_PORTS-1:0] be_q;
    word_t      [NUM_WR_PORTS-1:0] load_q;

    // Write request registers
    byte_en_t   [NUM_WR_PORTS-1:0] wr_be_q;
    vreg_addr_t [NUM_WR_PORTS-1:0] wr_addr_q;
    word_t      [NUM_WR_PORTS-1:0] wr_data_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            wr_be_q <= '0;
        end else begin
            for (int j = 0; j < NUM_WR_PORTS; j++) begin
                valid_q[j] <= op_i[j].valid;
                // No write for an empty slot
                wr_be_q[j] <= valid_q[j] ? be_q[j] : '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int j = 0; j < NUM_WR_PORTS; j++) begin
            waddr_q[j]   <= op_i[j].waddr;
            wb_sel_q[j]  <= op_i[j].wb_sel;
            be_q[j]      <= op_i[j].byte_en;
            load_q[j]    <= op_i[j].load_data;
            wr_addr_q[j] <= waddr_q[j];
            // Load data or ALU result
            wr_data_q[j] <= (wb_sel_q[j] == WB_LOAD) ? load_q[j] : result_i[j].data;
        end
    end

    always_comb begin
        for (int j = 0; j < NUM_WR_PORTS; j++) begin
            wr_o[j].waddr   = wr_addr_q[j];
            wr_o[j].wdata   = wr_data_q[j];
            wr_o[j].byte_en = wr_be_q[j];
        end
    end

endmodule

// ==== vector_lane.sv ====
module vector_lane (
    input  logic                                                  clk_i,
    input  logic                                                  rst_i,
    input  lane_cfg_pkg::sew_t                                    sew_i,
    input  lane_op_pkg::rd_req_t   [lane_cfg_pkg::NUM_RD_PORTS-1:0] rd_req_i,
    input  lane_op_pkg::slot_op_t  [lane_cfg_pkg::NUM_WR_PORTS-1:0] slot_op_i,
    output lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] result_o,
    output lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] store_o
);

    import lane_cfg_pkg::*;
    import lane_op_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Stage interconnect
    //////////////////////////////////////////////////////////////////////

    word_t     [NUM_RD_PORTS-1:0] rdata;
    elem_sel_t [NUM_RD_PORTS-1:0] elem_sel;
    word_t     [NUM_RD_PORTS-1:0] elem;
    slot_op_t  [NUM_WR_PORTS-1:0] op_al;
    wr_req_t   [NUM_WR_PORTS-1:0] wr;

    // Element index travels beside the read address
    always_comb begin
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            elem_sel[p] = rd_req_i[p].elem_sel;
        end
    end

    lane_vrf vrf_inst (
        .clk_i    (clk_i),
        .rd_req_i (rd_req_i),
        .wr_i     (wr),
        .rdata_o  (rdata)
    );

    lane_read_prep read_prep_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .sew_i      (sew_i),
        .elem_sel_i (elem_sel),
        .rdata_i    (rdata),
        .elem_o     (elem)
    );

    lane_ctrl_pipe ctrl_pipe_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .slot_op_i (slot_op_i),
        .slot_op_o (op_al)
    );

    lane_exec exec_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .elem_i   (elem),
        .op_i     (op_al),
        .result_o (result_o),
        .store_o  (store_o)
    );

    // Writeback keeps its own copy of the aligned control
    lane_writeback writeback_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .op_i     (op_al),
        .result_i (result_o),
        .wr_o     (wr)
    );

endmodule

// ==== lane_checker.sv ====
module lane_checker (
    input  logic                                                  clk_i,
    input  logic                                                  rst_i,
    input  lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] result_i,
    input  lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] store_i,
    input  logic                                                  exp_push_i,
    input  lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] exp_res_i,
    input  lane_op_pkg::lane_out_t [lane_cfg_pkg::NUM_WR_PORTS-1:0] exp_st_i,
    input  logic                   [lane_cfg_pkg::NUM_WR_PORTS-1:0] res_chk_i,
    input  logic                   [2:0]                          test_id_i,
    input  logic                                                  test_done_i,
    input  logic                                                  all_done_i,
    output int                                                    err_cnt_o
);

    import lane_cfg_pkg::*;
    import lane_op_pkg::*;

    // One expected output set, tagged with the edge it is due after
    typedef struct packed {
        int                              due;
        lane_out_t [NUM_WR_PORTS-1:0]    res;
        lane_out_t [NUM_WR_PORTS-1:0]    st;
        logic      [NUM_WR_PORTS-1:0]    chk;
        logic      [2:0]                 tid;
    } exp_t;

    exp_t exp_q[$];
    int   edge_n = 0;
    int   chk_cnt = 0;
    int   err_cnt = 0;
    int   tests_run = 0;
    int   tests_bad = 0;
    int   test_err [8];
    int   test_chk [8];
    // Test id seen at the latest edge
    logic [2:0] cur_tid;

    assign err_cnt_o = err_cnt;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "reset";
            3'd2:    return "load and store-back";
            3'd3:    return "random ALU";
            3'd4:    return "element extraction";
            3'd5:    return "byte enables";
            3'd6:    return "dependencies";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare(input logic [2:0] tid, input logic ok, input string msg);
        chk_cnt++;
        test_chk[tid]++;
        if (!ok) begin
            err_cnt++;
            test_err[tid]++;
            $display("ERR %0t: test %0d %s", $time, tid, msg);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Sample expectations at the issue edge, like the DUT does
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : collect
        exp_t e;
        edge_n  = edge_n + 1;
        cur_tid = test_id_i;
        if (exp_push_i && rst_i) begin
            e.due = edge_n + EXEC_LAT;
            e.res = exp_res_i;
            e.st  = exp_st_i;
            e.chk = res_chk_i;
            e.tid = test_id_i;
            exp_q.push_back(e);
        end
        if (test_done_i) begin
            tests_run++;
            if (test_err[test_id_i] != 0) begin
                tests_bad++;
            end
            $display("Test %0d (%s): %s, %0d checks, %0d errors", test_id_i,
                     test_name(test_id_i), (test_err[test_id_i] == 0) ? "PASS" : "FAIL",
                     test_chk[test_id_i], test_err[test_id_i]);
        end
        if (all_done_i) begin
            $display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
                     tests_run, tests_bad, chk_cnt, err_cnt);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Compare between edges, outputs are stable here
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin : check
        exp_t       e;
        logic       has;
        logic [2:0] tid;
        has = 1'b0;
        e   = '0;
        // Stale head means an output set was skipped
        while (exp_q.size() > 0 && exp_q[0].due < edge_n) begin
            e = exp_q.pop_front();
            compare(e.tid, 1'b0, "an expected output was never compared");
        end
        if (exp_q.size() > 0 && exp_q[0].due == edge_n) begin
            e   = exp_q.pop_front();
            has = 1'b1;
        end
        tid = has ? e.tid : cur_tid;
        for (int j = 0; j < NUM_WR_PORTS; j++) begin
            // Nothing due means both valids low
            compare(tid, result_i[j].valid === (has && e.res[j].valid),
                    $sformatf("slot %0d result valid %b", j, result_i[j].valid));
            compare(tid, store_i[j].valid === (has && e.st[j].valid),
                    $sformatf("slot %0d store valid %b", j, store_i[j].valid));
            if (has && e.res[j].valid && e.chk[j]) begin
                compare(tid, result_i[j].data === e.res[j].data,
                        $sformatf("slot %0d result %h, expected %h", j,
                                  result_i[j].data, e.res[j].data));
            end
            if (has && e.st[j].valid) begin
                compare(tid, store_i[j].data === e.st[j].data,
                        $sformatf("slot %0d store %h, expected %h", j,
                                  store_i[j].data, e.st[j].data));
            end
        end
    end

endmodule

// ==== tb_vector_lane.sv ====
module tb_vector_lane;

    import lane_cfg_pkg::*;
    import lane_op_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 4;
    localparam int GAP        = 8;
    localparam int LOAD_CYC   = VREG_DEPTH / NUM_WR_PORTS;
    localparam int N_ALU      = 40;
    localparam int N_ELEM     = 20;
    localparam int N_BE       = 40;
    localparam int N_DEP      = 60;
    // Every phase of the run, in cycles
    localparam int TOTAL_CYC  = RST_CYCLES + 6 + 2 * LOAD_CYC + N_ALU + 3 * N_ELEM
                              + N_BE + 2 + N_DEP + 14 * GAP;
    localparam int MARGIN     = 50;

    // Pending model write
    typedef struct packed {
        int         due;
        vreg_addr_t addr;
        word_t      data;
        byte_en_t   be;
    } pend_t;

    logic clk_i;
    logic rst_i;
    sew_t sew_i;
    rd_req_t   [NUM_RD_PORTS-1:0] rd_req_i;
    slot_op_t  [NUM_WR_PORTS-1:0] slot_op_i;
    lane_out_t [NUM_WR_PORTS-1:0] result_o;
    lane_out_t [NUM_WR_PORTS-1:0] store_o;

    // Checker side
    logic                    exp_push;
    lane_out_t [NUM_WR_PORTS-1:0] exp_res;
    lane_out_t [NUM_WR_PORTS-1:0] exp_st;
    logic [NUM_WR_PORTS-1:0] res_chk;
    logic [2:0]              test_id;
    logic                    test_done;
    logic                    all_done;
    int                      err_cnt;

    // Next cycle's stimulus
    rd_req_t  [NUM_RD_PORTS-1:0] nxt_rd;
    slot_op_t [NUM_WR_PORTS-1:0] nxt_op;
    sew_t                        nxt_sew;
    logic     [NUM_WR_PORTS-1:0] nxt_chk;
    logic                        done_next;
    // Test id applied with the next issue
    logic     [2:0]              nxt_tid;

    // Reference VRF and its write queue
    word_t vrf_m [VREG_DEPTH];
    pend_t pend_q[$];
    int    issue_n;
    int    seed;

    vector_lane vector_lane_inst (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .sew_i     (sew_i),
        .rd_req_i  (rd_req_i),
        .slot_op_i (slot_op_i),
        .result_o  (result_o),
        .store_o   (store_o)
    );

    lane_checker checker_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .result_i    (result_o),
        .store_i     (store_o),
        .exp_push_i  (exp_push),
        .exp_res_i   (exp_res),
        .exp_st_i    (exp_st),
        .res_chk_i   (res_chk),
        .test_id_i   (test_id),
        .test_done_i (test_done),
        .all_done_i  (all_done),
        .err_cnt_o   (err_cnt)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Watchdog
    initial begin
        #((TOTAL_CYC + MARGIN) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_CYC + MARGIN);
        $display("test failed");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Zero-extended element, SEW 3 reads as zero
    function automatic word_t extract_elem(input word_t w, input sew_t s, input elem_sel_t idx);
        case (s)
            2'd0:    return (w >> (8 * idx)) & 32'h0000_00ff;
            2'd1:    return (w >> (16 * idx[0])) & 32'h0000_ffff;
            2'd2:    return w;
            default: return 32'h0;
        endcase
    endfunction

    function automatic word_t alu_ref(input alu_op_t op, input word_t a, input word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_SRL:  return a >> b[4:0];
            default: return (a > b) ? a : b;
        endcase
    endfunction

    // Writes of older issues land in queue order, higher port last
    task automatic apply_due_writes();
        pend_t pw;
        while (pend_q.size() > 0 && pend_q[0].due <= issue_n) begin
            pw = pend_q.pop_front();
            for (int b = 0; b < 4; b++) begin
                if (pw.be[b]) begin
                    vrf_m[pw.addr][8*b +: 8] = pw.data[8*b +: 8];
                end
            end
        end
    endtask

    // One issue cycle, with the expected outputs beside it
    task automatic drive_cycle();
        word_t elem_m [NUM_RD_PORTS];
        word_t b;
        word_t res;
        pend_t pw;
        @(negedge clk_i);
        issue_n++;
        apply_due_writes();
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            elem_m[p] = extract_elem(vrf_m[nxt_rd[p].raddr], nxt_sew, nxt_rd[p].elem_sel);
        end
        for (int j = 0; j < NUM_WR_PORTS; j++) begin
            case (nxt_op[j].op2_sel)
                SRC_VEC: b = elem_m[2*j+1];
                SRC_X:   b = nxt_op[j].x_data;
                SRC_IMM: b = {27'b0, nxt_op[j].imm};
                default: b = 32'h0;
            endcase
            res = alu_ref(nxt_op[j].alu_op, elem_m[2*j], b);
            exp_res[j].valid = nxt_op[j].valid;
            exp_res[j].data  = res;
            exp_st[j].valid  = nxt_op[j].store_valid;
            exp_st[j].data   = elem_m[nxt_op[j].store_sel];
            if (nxt_op[j].valid) begin
                pw.due  = issue_n + WRITE_VIS;
                pw.addr = nxt_op[j].waddr;
                pw.data = (nxt_op[j].wb_sel == WB_LOAD) ? nxt_op[j].load_data : res;
                pw.be   = nxt_op[j].byte_en;
                pend_q.push_back(pw);
            end
        end
        res_chk   = nxt_chk;
        rd_req_i  = nxt_rd;
        slot_op_i = nxt_op;
        sew_i     = nxt_sew;
        exp_push  = 1'b1;
        test_id   = nxt_tid;
        test_done = done_next;
        done_next = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic random_reads();
        logic [31:0] r;
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            r = $random(seed);
            nxt_rd[p].raddr    = r[4:0];
            nxt_rd[p].elem_sel = r[9:8];
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            random_reads();
            nxt_op  = '0;
            nxt_chk = '1;
            drive_cycle();
        end
    endtask

    task automatic end_test();
        idle_cycles(GAP - 1);
        done_next = 1'b1;
        idle_cycles(1);
    endtask

    task automatic load_all();
        for (int k = 0; k < LOAD_CYC; k++) begin
            random_reads();
            nxt_op = '0;
            for (int j = 0; j < NUM_WR_PORTS; j++) begin
                nxt_op[j].valid     = 1'b1;
                nxt_op[j].wb_sel    = WB_LOAD;
                nxt_op[j].waddr     = vreg_addr_t'(NUM_WR_PORTS * k + j);
                nxt_op[j].byte_en   = 4'hf;
                nxt_op[j].load_data = $random(seed);
            end
            // Operands are not yet defined
            nxt_chk = '0;
            drive_cycle();
        end
    endtask

    task automatic store_back(input int first, input int count);
        for (int k = 0; k < count; k += NUM_WR_PORTS) begin
            random_reads();
            nxt_op = '0;
            for (int j = 0; j < NUM_WR_PORTS; j++) begin
                nxt_rd[j].raddr       = vreg_addr_t'(first + k + j);
                nxt_op[j].store_valid = 1'b1;
                nxt_op[j].store_sel   = rd_sel_t'(j);
            end
            nxt_chk = '1;
            drive_cycle();
        end
    endtask

    task automatic random_cycle(input vreg_addr_t amask, input logic rand_be,
                                input logic rand_wb, input logic st_on);
        logic [31:0] r;
        logic [31:0] s;
        random_reads();
        for (int p = 0; p < NUM_RD_PORTS; p++) begin
            nxt_rd[p].raddr = nxt_rd[p].raddr & amask;
        end
        for (int j = 0; j < NUM_WR_PORTS; j++) begin
            r = $random(seed);
            s = $random(seed);
            nxt_op[j].valid       = (r[1:0] != 2'b00);
            nxt_op[j].alu_op      = r[4:2];
            nxt_op[j].op2_sel     = op2_sel_t'(r[15:8] % 8'd3);
            nxt_op[j].x_data      = $random(seed);
            nxt_op[j].imm         = r[20:16];
            nxt_op[j].wb_sel      = rand_wb ? r[21] : WB_ALU;
            nxt_op[j].waddr       = r[28:24] & amask;
            nxt_op[j].byte_en     = rand_be ? s[3:0] : 4'hf;
            nxt_op[j].load_data   = $random(seed);
            nxt_op[j].store_valid = st_on & s[4];
            nxt_op[j].store_sel   = s[9:8];
        end
        // Same-address pair now and then
        r = $random(seed);
        if (rand_be && r[1:0] == 2'b00) begin
            nxt_op[1].waddr = nxt_op[0].waddr;
        end
        nxt_chk = '1;
        drive_cycle();
    endtask

    initial begin
        seed      = 32'h660c_a322;
        issue_n   = 0;
        rst_i     = 1'b0;
        sew_i     = SEW_32;
        rd_req_i  = '0;
        slot_op_i = '0;
        exp_push  = 1'b0;
        exp_res   = '0;
        exp_st    = '0;
        res_chk   = '0;
        test_id   = 3'd1;
        test_done = 1'b0;
        all_done  = 1'b0;
        nxt_rd    = '0;
        nxt_op    = '0;
        nxt_sew   = SEW_32;
        nxt_chk   = '1;
        done_next = 1'b0;
        nxt_tid   = 3'd1;
        repeat (RST_CYCLES) @(negedge clk_i);
        rst_i = 1'b1;

        // Valids must stay low with nothing issued
        idle_cycles(6);
        end_test();

        nxt_tid = 3'd2;
        load_all();
        idle_cycles(GAP);
        store_back(0, VREG_DEPTH);
        end_test();

        nxt_tid = 3'd3;
        repeat (N_ALU) random_cycle(5'h1f, 1'b0, 1'b0, 1'b0);
        end_test();

        // SEW changes only after the pipe has drained
        nxt_tid = 3'd4;
        for (int k = 0; k < 3; k++) begin
            nxt_sew = (k == 2) ? sew_t'(2'd3) : sew_t'(k);
            repeat (N_ELEM) random_cycle(5'h1f, 1'b0, 1'b0, 1'b1);
            idle_cycles(GAP);
        end
        nxt_sew = SEW_32;
        end_test();

        nxt_tid = 3'd5;
        repeat (N_BE) random_cycle(5'h03, 1'b1, 1'b1, 1'b1);
        idle_cycles(GAP);
        store_back(0, 4);
        end_test();

        // Small address range keeps reads close behind writes
        nxt_tid = 3'd6;
        repeat (N_DEP) random_cycle(5'h03, 1'b1, 1'b1, 1'b1);
        end_test();

        @(negedge clk_i);
        test_done = 1'b0;
        all_done  = 1'b1;
        @(negedge clk_i);
        all_done = 1'b0;
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
lane_cfg_pkg.sv
lane_op_pkg.sv
lane_vrf.sv
lane_read_prep.sv
lane_ctrl_pipe.sv
lane_exec.sv
lane_writeback.sv
vector_lane.sv
lane_checker.sv
tb_vector_lane.sv

// ==== Makefile ====
# Verilator build and run of the vector lane testbench

VERILATOR ?= verilator
TOP       ?= tb_vector_lane
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= test passed

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
